// ==== verilog.f ====
td_pkg.sv
td_params_if.sv
td_seq_divider.sv
td_param_capture.sv
td_timing_calc.sv
timing_decision_top.sv
tb_timing_decision.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the timing decision testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_timing_decision \
    -f verilog.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb_timing_decision.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_timing_decision;

    import td_pkg::*;

    localparam int DIV_WIDTH    = 48;
    localparam int NUM_SESSIONS = 40;
    localparam int WAIT_LIMIT   = 6 * (DIV_WIDTH + 10) + 50;  // one session worth of cycles
    localparam int WATCHDOG     = (NUM_SESSIONS + 1) * WAIT_LIMIT;  // plus the long hold

    logic clk, rst_n;
    logic [9:0]  ms_stm_bw;
    logic        ms_stm_bw_valid, spm_iso_start, spm_msa_vld;
    logic [2:0]  spm_lane_count;
    logic [15:0] spm_lane_bw, htotal, hwidth, vtotal, vheight;
    logic [7:0]  misc0, misc1;
    logic        h_sync_polarity, v_sync_polarity;
    logic        td_vld_data, td_hsync_polarity, td_vsync_polarity;
    logic [1:0]  td_lane_count;
    logic [15:0] td_h_active_ctr, td_h_total_ctr;
    logic [13:0] td_h_blank_ctr;
    logic [9:0]  td_v_blank_ctr;
    logic [12:0] td_v_active_ctr;
    logic [5:0]  td_tu_vld_data_size, td_tu_stuffed_data_size;
    logic [8:0]  td_misc0_1;

    integer seed = 32'h31ef;
    int     checks = 0;
    int     errors = 0;
    int     sess_err;
    int     sess;
    logic [8:0] fmt;
    int unsigned exp_h_active, exp_h_blank, exp_h_total, exp_tu_vld, exp_tu_stuff;

    timing_decision_top #(.DIV_WIDTH(DIV_WIDTH)) DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ==============================
    // helpers
    // ==============================

    function automatic int unsigned pick_between(input int unsigned lo, input int unsigned hi);
        int unsigned r;
        r = {$random(seed)};
        return lo + (r % (hi - lo + 1));
    endfunction

    task automatic compare_field(input string name, input int unsigned expected,
                                 input int unsigned actual);
        checks++;
        if (expected != actual)
        begin
            errors++;
            sess_err++;
            $display("[FAIL] %s session %0d expected %0d actual %0d", name, sess, expected, actual);
        end
    endtask

    // reference model with truncating divisions
    task automatic compute_expected();
        int unsigned bpc, spp, bpp, weq, sym, x, span, str_q;
        longint unsigned q;
        case (fmt)
            FMT_RGB_8, FMT_YCC444_8:
            begin
                bpc = 8;
                spp = 3;
                bpp = 24;
            end
            FMT_RGB_16, FMT_YCC444_16:
            begin
                bpc = 16;
                spp = 6;
                bpp = 48;
            end
            default:
            begin
                bpc = 10;
                spp = 3;
                bpp = 30;
            end
        endcase
        weq  = (hwidth / spm_lane_count) * spm_lane_count;
        sym  = weq * bpc * spp / 8;
        x    = 0;
        if (hwidth % spm_lane_count != 0)
            x = (bpc == 8) ? 3 : (bpc == 16) ? 6 : 0;  // pad for the uneven split
        exp_h_active = (sym / spm_lane_count + x) & 16'hffff;
        span         = htotal - hwidth;
        exp_h_blank  = (span * spm_lane_bw / ms_stm_bw + 1) & 14'h3fff;
        exp_h_total  = (htotal * spm_lane_bw / ms_stm_bw) & 16'hffff;
        str_q        = ((ms_stm_bw * bpp) / 8) / spm_lane_count;
        q            = (longint'(str_q) * 64 * 1024) / spm_lane_bw;
        exp_tu_vld   = (q / 1024) & 6'h3f;
        exp_tu_stuff = (64 - (q / 1024)) & 6'h3f;
    endtask

    task automatic draw_session();
        int unsigned cap;
        case (pick_between(0, 2))
            0:       spm_lane_count = 3'd1;
            1:       spm_lane_count = 3'd2;
            default: spm_lane_count = 3'd4;
        endcase
        // keep stream symbols within the link so the valid size stays in 1..64
        spm_lane_bw = 16'(pick_between(100, 1000));
        while (spm_lane_count * spm_lane_bw < 300)
            spm_lane_bw = 16'(pick_between(100, 1000));
        cap = spm_lane_count * spm_lane_bw / 6;
        if (cap > 1000)
            cap = 1000;
        ms_stm_bw = 10'(pick_between(50, cap));
        hwidth    = 16'(pick_between(64, 4000));
        htotal    = hwidth + 16'(pick_between(16, 1000));
        vheight   = 16'(pick_between(32, 2000));
        vtotal    = vheight + 16'(pick_between(1, 500));
        case (pick_between(0, 4))
            0:       fmt = FMT_RGB_8;
            1:       fmt = FMT_RGB_16;
            2:       fmt = FMT_YCC444_8;
            3:       fmt = FMT_YCC444_16;
            default: fmt = 9'h020;  // not a listed code
        endcase
        misc0 = {fmt[6:0], 1'(pick_between(0, 1))};   // bit 0 is not part of the word
        misc1 = {fmt[8:7], 6'(pick_between(0, 63))};
        h_sync_polarity = 1'(pick_between(0, 1));
        v_sync_polarity = 1'(pick_between(0, 1));
    endtask

    task automatic check_cleared(input string tag);
        compare_field({tag, "_vld"}, 0, td_vld_data);
        compare_field({tag, "_h_active"}, 0, td_h_active_ctr);
        compare_field({tag, "_h_blank"}, 0, td_h_blank_ctr);
        compare_field({tag, "_h_total"}, 0, td_h_total_ctr);
        compare_field({tag, "_v_blank"}, 0, td_v_blank_ctr);
        compare_field({tag, "_v_active"}, 0, td_v_active_ctr);
        compare_field({tag, "_tu_vld"}, 0, td_tu_vld_data_size);
        compare_field({tag, "_tu_stuffed"}, 0, td_tu_stuffed_data_size);
        compare_field({tag, "_hsync_pol"}, 0, td_hsync_polarity);
        compare_field({tag, "_vsync_pol"}, 0, td_vsync_polarity);
        compare_field({tag, "_misc"}, 0, td_misc0_1);
        compare_field({tag, "_lanes"}, 0, td_lane_count);
    endtask

    task automatic check_results();
        compare_field("h_active", exp_h_active, td_h_active_ctr);
        compare_field("h_blank", exp_h_blank, td_h_blank_ctr);
        compare_field("h_total", exp_h_total, td_h_total_ctr);
        compare_field("v_blank", vtotal - vheight, td_v_blank_ctr);
        compare_field("v_active", vheight, td_v_active_ctr);
        compare_field("tu_vld_size", exp_tu_vld, td_tu_vld_data_size);
        compare_field("tu_stuffed_size", exp_tu_stuff, td_tu_stuffed_data_size);
        compare_field("lane_count", spm_lane_count - 1, td_lane_count);
        compare_field("hsync_pol", h_sync_polarity, td_hsync_polarity);
        compare_field("vsync_pol", v_sync_polarity, td_vsync_polarity);
        compare_field("misc0_1", fmt, td_misc0_1);
    endtask

    // ==============================
    // watchdog
    // ==============================

    initial
    begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
        $display("Result: FAILED");
        $finish;
    end

    // ==============================
    // main sequence
    // ==============================

    initial
    begin
        int cnt;
        rst_n = 1'b0;
        ms_stm_bw = '0;
        ms_stm_bw_valid = 1'b0;
        spm_iso_start = 1'b0;
        spm_lane_count = '0;
        spm_lane_bw = '0;
        htotal = '0;
        hwidth = '0;
        vtotal = '0;
        vheight = '0;
        misc0 = '0;
        misc1 = '0;
        spm_msa_vld = 1'b0;
        h_sync_polarity = 1'b0;
        v_sync_polarity = 1'b0;
        fmt = '0;
        sess = 0;
        sess_err = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_cleared("reset");
        $display("reset test: %s", (sess_err == 0) ? "ok" : "mismatch");

        for (sess = 1; sess <= NUM_SESSIONS; sess++)
        begin
            sess_err = 0;
            draw_session();
            compute_expected();
            spm_iso_start = 1'b1;  // lane info taken on this rise
            @(negedge clk);
            ms_stm_bw_valid = 1'b1;
            @(negedge clk);
            ms_stm_bw_valid = 0;
            // first session holds the attributes back longer than a whole calculation
            repeat ((sess == 1) ? WAIT_LIMIT : 3)
            begin
                @(negedge clk);
                compare_field("vld_before_msa", 0, td_vld_data);  // attributes still missing
            end
            spm_msa_vld = 1'b1;
            @(negedge clk);
            spm_msa_vld = 1'b0;
            cnt = 0;
            while (!td_vld_data && cnt < WAIT_LIMIT)
            begin
                @(negedge clk);
                cnt++;
            end
            if (!td_vld_data)
            begin
                errors++;
                sess_err++;
                $display("session %0d: td_vld_data never rose within %0d cycles", sess, cnt);
            end
            else
            begin
                check_results();
                repeat (4) @(negedge clk);
                compare_field("hold_vld", 1, td_vld_data);  // set must stay put
                compare_field("hold_h_total", exp_h_total, td_h_total_ctr);
                compare_field("hold_tu_vld_size", exp_tu_vld, td_tu_vld_data_size);
            end
            spm_iso_start = 1'b0;  // end of session
            repeat (3) @(negedge clk);
            check_cleared("cleared");
            $display("session %0d fmt %03h lanes %0d stm_bw %0d lane_bw %0d: %s", sess, fmt,
                     spm_lane_count, ms_stm_bw, spm_lane_bw, (sess_err == 0) ? "ok" : "mismatch");
        end

        $display("done: %0d sessions, %0d checks, %0d errors", NUM_SESSIONS, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== timing_decision_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module timing_decision_top
    import td_pkg::*;
#(
    parameter int DIV_WIDTH = DIV_WIDTH_DEFAULT   // shared divider width
)
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [9:0]  ms_stm_bw,
    input  wire         ms_stm_bw_valid,
    input  wire         spm_iso_start,
    input  wire  [2:0]  spm_lane_count,
    input  wire  [15:0] spm_lane_bw,
    input  wire  [15:0] htotal,
    input  wire  [15:0] hwidth,
    input  wire  [15:0] vtotal,
    input  wire  [15:0] vheight,
    input  wire  [7:0]  misc0,
    input  wire  [7:0]  misc1,
    input  wire         spm_msa_vld,
    input  wire         h_sync_polarity,
    input  wire         v_sync_polarity,
    output wire         td_vld_data,
    output wire  [1:0]  td_lane_count,
    output wire  [15:0] td_h_active_ctr,
    output wire  [13:0] td_h_blank_ctr,
    output wire  [15:0] td_h_total_ctr,
    output wire  [9:0]  td_v_blank_ctr,
    output wire  [12:0] td_v_active_ctr,
    output wire  [5:0]  td_tu_vld_data_size,
    output wire  [5:0]  td_tu_stuffed_data_size,
    output wire         td_hsync_polarity,
    output wire         td_vsync_polarity,
    output wire  [8:0]  td_misc0_1
);

    td_params_if params_bus ();  // captured set, capture -> calc

    td_param_capture u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .ms_stm_bw       (ms_stm_bw),
        .ms_stm_bw_valid (ms_stm_bw_valid),
        .spm_iso_start   (spm_iso_start),
        .spm_lane_count  (spm_lane_count),
        .spm_lane_bw     (spm_lane_bw),
        .htotal          (htotal),
        .hwidth          (hwidth),
        .vtotal          (vtotal),
        .vheight         (vheight),
        .misc0           (misc0),
        .misc1           (misc1),
        .spm_msa_vld     (spm_msa_vld),
        .params          (params_bus.capture)
    );

    td_timing_calc #(
        .DIV_WIDTH (DIV_WIDTH)
    ) u_calc (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .params                  (params_bus.calc),
        .h_sync_polarity         (h_sync_polarity),
        .v_sync_polarity         (v_sync_polarity),
        .td_vld_data             (td_vld_data),
        .td_lane_count           (td_lane_count),
        .td_h_active_ctr         (td_h_active_ctr),
        .td_h_blank_ctr          (td_h_blank_ctr),
        .td_h_total_ctr          (td_h_total_ctr),
        .td_v_blank_ctr          (td_v_blank_ctr),
        .td_v_active_ctr         (td_v_active_ctr),
        .td_tu_vld_data_size     (td_tu_vld_data_size),
        .td_tu_stuffed_data_size (td_tu_stuffed_data_size),
        .td_hsync_polarity       (td_hsync_polarity),
        .td_vsync_polarity       (td_vsync_polarity),
        .td_misc0_1              (td_misc0_1)
    );

endmodule

`default_nettype wire

// ==== td_timing_calc.sv ====
`timescale 1ns/10ps
`default_nettype none

module td_timing_calc
    import td_pkg::*;
#(
    parameter int DIV_WIDTH = DIV_WIDTH_DEFAULT
)
(
    input  wire          clk,
    input  wire          rst_n,
    td_params_if.calc    params,
    input  wire          h_sync_polarity,
    input  wire          v_sync_polarity,
    output logic         td_vld_data,              // result set valid
    output logic [1:0]   td_lane_count,            // lanes - 1
    output logic [15:0]  td_h_active_ctr,
    output logic [13:0]  td_h_blank_ctr,
    output logic [15:0]  td_h_total_ctr,
    output logic [9:0]   td_v_blank_ctr,
    output logic [12:0]  td_v_active_ctr,
    output logic [5:0]   td_tu_vld_data_size,
    output logic [5:0]   td_tu_stuffed_data_size,
    output logic         td_hsync_polarity,
    output logic         td_vsync_polarity,
    output logic [8:0]   td_misc0_1
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ISSUE  = 2'd1;  // div_start high
    localparam logic [1:0] ST_WAIT   = 2'd2;  // division running
    localparam logic [1:0] ST_HOLD   = 2'd3;  // results out, wait for session end
    localparam logic [2:0] LAST_STEP = 3'd5;

    logic [1:0]           state;
    logic [2:0]           step;       // which division is in flight
    logic                 step_done;
    logic                 last_done;

    logic [4:0]           bpc;        // bits per component
    logic [2:0]           spp;        // symbols per pixel
    logic [5:0]           bpp;        // bits per pixel

    logic [15:0]          w_div;      // hwidth / lanes
    logic [15:0]          act_q;      // active symbols per lane, with x added
    logic [13:0]          blank_q;
    logic [15:0]          total_q;
    logic [15:0]          str_q;      // stream symbols per lane

    logic [18:0]          w_eq;       // hwidth cut to a multiple of lanes
    logic [2:0]           x_adj;
    logic [DIV_WIDTH-1:0] sym_cnt;
    logic [DIV_WIDTH-1:0] str_num;
    logic [DIV_WIDTH-1:0] tu_num;
    logic [5:0]           tu_vld;
    logic [6:0]           tu_stuff;
    logic [15:0]          v_blank;
    logic [2:0]           lanes_m1;

    logic                 div_start;
    logic                 div_done;
    logic [DIV_WIDTH-1:0] div_dividend;
    logic [DIV_WIDTH-1:0] div_divisor;
    logic [DIV_WIDTH-1:0] div_quotient;

    // ==============================
    // format decode
    // ==============================

    always_comb
    begin
        case (params.fmt)
            FMT_RGB_8, FMT_YCC444_8:
            begin
                bpc = 5'd8;
                spp = 3'd3;
                bpp = 6'd24;
            end
            FMT_RGB_16, FMT_YCC444_16:
            begin
                bpc = 5'd16;
                spp = 3'd6;
                bpp = 6'd48;
            end
            default:  // treated as 10 bpc
            begin
                bpc = 5'd10;
                spp = 3'd3;
                bpp = 6'd30;
            end
        endcase
    end

    // ==============================
    // arithmetic between divisions
    // ==============================

    assign w_eq    = w_div * params.lanes;
    // pad only when hwidth does not split evenly across lanes
    assign x_adj   = (w_eq == 19'(params.hwidth)) ? 3'd0 :
                     (bpc == 5'd8)                 ? 3'd3 :
                     (bpc == 5'd16)                ? 3'd6 : 3'd0;
    assign sym_cnt = DIV_WIDTH'(w_eq) * DIV_WIDTH'(bpc) * DIV_WIDTH'(spp)
                     / DIV_WIDTH'(SYMBOL_BITS);
    assign str_num = DIV_WIDTH'(params.stm_bw) * DIV_WIDTH'(bpp) / DIV_WIDTH'(SYMBOL_BITS);
    assign tu_num  = (DIV_WIDTH'(str_q) * DIV_WIDTH'(TU_SIZE)) << FP_PRECISION;

    always_comb
    begin
        case (step)
            3'd0:    div_dividend = DIV_WIDTH'(params.hwidth);
            3'd1:    div_dividend = sym_cnt;
            3'd2:    div_dividend = DIV_WIDTH'(params.htotal - params.hwidth)
                                    * DIV_WIDTH'(params.lane_bw);
            3'd3:    div_dividend = DIV_WIDTH'(params.htotal) * DIV_WIDTH'(params.lane_bw);
            3'd4:    div_dividend = str_num;
            default: div_dividend = tu_num;
        endcase
        case (step)
            3'd2, 3'd3: div_divisor = DIV_WIDTH'(params.stm_bw);   // link time per pixel
            3'd5:       div_divisor = DIV_WIDTH'(params.lane_bw);
            default:    div_divisor = DIV_WIDTH'(params.lanes);
        endcase
    end

    assign div_start = (state == ST_ISSUE);
    assign step_done = (state == ST_WAIT) && div_done;
    assign last_done = step_done && (step == LAST_STEP);

    td_seq_divider #(
        .DIV_WIDTH (DIV_WIDTH)
    ) u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .dividend (div_dividend),
        .divisor  (div_divisor),
        .quotient (div_quotient),
        .done     (div_done)
    );

    // ==============================
    // step sequencer
    // ==============================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ST_IDLE;
            step  <= 3'd0;
        end
        else if (!params.all_saved)  // session over or not yet complete
        begin
            state <= ST_IDLE;
            step  <= 3'd0;
        end
        else
        begin
            case (state)
                ST_IDLE:  state <= ST_ISSUE;
                ST_ISSUE: state <= ST_WAIT;
                ST_WAIT:
                begin
                    if (div_done)
                    begin
                        step  <= step + 3'd1;
                        state <= (step == LAST_STEP) ? ST_HOLD : ST_ISSUE;
                    end
                end
                default:  state <= ST_HOLD;  // one result set per session
            endcase
        end
    end

    // quotients of steps 0..4, step 5 goes straight to the outputs
    always_ff @(posedge clk)
    begin
        if (step_done)
        begin
            case (step)
                3'd0:    w_div   <= div_quotient[15:0];
                3'd1:    act_q   <= div_quotient[15:0] + 16'(x_adj);
                3'd2:    blank_q <= div_quotient[13:0] + 14'd1;
                3'd3:    total_q <= div_quotient[15:0];
                3'd4:    str_q   <= div_quotient[15:0];
                default: str_q   <= str_q;
            endcase
        end
    end

    // ==============================
    // result registers
    // ==============================

    assign tu_vld   = div_quotient[FP_PRECISION+5:FP_PRECISION];  // integer part
    assign tu_stuff = 7'(TU_SIZE) - {1'b0, tu_vld};
    assign v_blank  = params.vtotal - params.vheight;
    assign lanes_m1 = params.lanes - 3'd1;  // 1/2/4 -> 0/1/3

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            td_vld_data             <= 1'b0;
            td_lane_count           <= '0;
            td_h_active_ctr         <= '0;
            td_h_blank_ctr          <= '0;
            td_h_total_ctr          <= '0;
            td_v_blank_ctr          <= '0;
            td_v_active_ctr         <= '0;
            td_tu_vld_data_size     <= '0;
            td_tu_stuffed_data_size <= '0;
            td_hsync_polarity       <= 1'b0;
            td_vsync_polarity       <= 1'b0;
            td_misc0_1              <= '0;
        end
        else if (!params.all_saved)
        begin
            td_vld_data             <= 1'b0;
            td_lane_count           <= '0;
            td_h_active_ctr         <= '0;
            td_h_blank_ctr          <= '0;
            td_h_total_ctr          <= '0;
            td_v_blank_ctr          <= '0;
            td_v_active_ctr         <= '0;
            td_tu_vld_data_size     <= '0;
            td_tu_stuffed_data_size <= '0;
            td_hsync_polarity       <= 1'b0;
            td_vsync_polarity       <= 1'b0;
            td_misc0_1              <= '0;
        end
        else if (last_done)
        begin
            td_vld_data             <= 1'b1;
            td_lane_count           <= lanes_m1[1:0];
            td_h_active_ctr         <= act_q;
            td_h_blank_ctr          <= blank_q;
            td_h_total_ctr          <= total_q;
            td_v_blank_ctr          <= v_blank[9:0];
            td_v_active_ctr         <= params.vheight[12:0];
            td_tu_vld_data_size     <= tu_vld;
            td_tu_stuffed_data_size <= tu_stuff[5:0];  // 64 - valid, wraps at 64
            td_hsync_polarity       <= h_sync_polarity;
            td_vsync_polarity       <= v_sync_polarity;
            td_misc0_1              <= params.fmt;
        end
    end

endmodule

`default_nettype wire

// ==== td_param_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module td_param_capture
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire  [9:0]   ms_stm_bw,        // stream bandwidth
    input  wire          ms_stm_bw_valid,
    input  wire          spm_iso_start,    // session open while high
    input  wire  [2:0]   spm_lane_count,
    input  wire  [15:0]  spm_lane_bw,
    input  wire  [15:0]  htotal,
    input  wire  [15:0]  hwidth,
    input  wire  [15:0]  vtotal,
    input  wire  [15:0]  vheight,
    input  wire  [7:0]   misc0,
    input  wire  [7:0]   misc1,
    input  wire          spm_msa_vld,      // main stream attributes strobe
    td_params_if.capture params
);

    logic iso_d;       // spm_iso_start one clock late
    logic iso_rise;    // lane info is taken here
    logic msa_saved;
    logic bw_saved;
    logic lane_saved;

    assign iso_rise = spm_iso_start & ~iso_d;

    // ==============================
    // captured values
    // ==============================

    always_ff @(posedge clk)
    begin
        if (spm_msa_vld)
        begin
            params.htotal  <= htotal;
            params.hwidth  <= hwidth;
            params.vtotal  <= vtotal;
            params.vheight <= vheight;
            params.fmt     <= {misc1[7:6], misc0[7:1]};  // colorimetry + bpc bits
        end
        if (ms_stm_bw_valid)
        begin
            params.stm_bw <= ms_stm_bw;
        end
        if (iso_rise)
        begin
            params.lane_bw <= spm_lane_bw;
            params.lanes   <= spm_lane_count;
        end
    end

    // ==============================
    // saved flags
    // ==============================

    // a flag falls on any cycle with the session closed and no fresh capture
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            iso_d            <= 1'b0;
            msa_saved        <= 1'b0;
            bw_saved         <= 1'b0;
            lane_saved       <= 1'b0;
            params.all_saved <= 1'b0;
        end
        else
        begin
            iso_d      <= spm_iso_start;
            msa_saved  <= spm_msa_vld | (msa_saved & spm_iso_start);
            bw_saved   <= ms_stm_bw_valid | (bw_saved & spm_iso_start);
            lane_saved <= iso_rise | (lane_saved & spm_iso_start);
            params.all_saved <= msa_saved & bw_saved & lane_saved;  // one more stage
        end
    end

endmodule

`default_nettype wire

// ==== td_seq_divider.sv ====
`timescale 1ns/10ps
`default_nettype none

// restoring long division, one quotient bit per clock
module td_seq_divider
    import td_pkg::*;
#(
    parameter int DIV_WIDTH = DIV_WIDTH_DEFAULT
)
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start,     // latches operands, restarts a running division
    input  wire  [DIV_WIDTH-1:0]  dividend,
    input  wire  [DIV_WIDTH-1:0]  divisor,
    output logic [DIV_WIDTH-1:0]  quotient,  // holds until next start
    output logic                  done       // DIV_WIDTH cycles after start
);

    localparam int CNT_W = $clog2(DIV_WIDTH + 1);

    logic                 busy;
    logic [CNT_W-1:0]     bit_cnt;  // quotient bits still to produce
    logic [DIV_WIDTH-1:0] rem_q;    // partial remainder
    logic [DIV_WIDTH-1:0] dvsr_q;
    logic [DIV_WIDTH:0]   trial;    // remainder with next dividend bit brought down
    logic [DIV_WIDTH:0]   diff;

    // dividend bits leave the top of quotient while result bits enter at the bottom
    assign trial = {rem_q, quotient[DIV_WIDTH-1]};
    assign diff  = trial - {1'b0, dvsr_q};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end
        else if (start)
        begin
            busy    <= 1'b1;
            bit_cnt <= CNT_W'(DIV_WIDTH);
            done    <= 1'b0;
        end
        else if (busy)
        begin
            bit_cnt <= bit_cnt - CNT_W'(1);
            busy    <= (bit_cnt != CNT_W'(1));
            done    <= (bit_cnt == CNT_W'(1));  // last bit goes in this clock
        end
        else
        begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rem_q    <= '0;
            quotient <= dividend;
            dvsr_q   <= divisor;
        end
        else if (busy)
        begin
            if (diff[DIV_WIDTH])  // borrow, keep old remainder
            begin
                rem_q    <= trial[DIV_WIDTH-1:0];
                quotient <= {quotient[DIV_WIDTH-2:0], 1'b0};
            end
            else
            begin
                rem_q    <= diff[DIV_WIDTH-1:0];
                quotient <= {quotient[DIV_WIDTH-2:0], 1'b1};
            end
        end
    end

endmodule

`default_nettype wire

// ==== td_params_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// captured attribute set, capture side to calculation side
interface td_params_if;

    logic [15:0] htotal;     // total pixels per line
    logic [15:0] hwidth;     // active pixels per line
    logic [15:0] vtotal;     // total lines per frame
    logic [15:0] vheight;    // active lines per frame
    logic [8:0]  fmt;        // {misc1[7:6], misc0[7:1]}
    logic [9:0]  stm_bw;     // stream bandwidth
    logic [15:0] lane_bw;    // per-lane bandwidth
    logic [2:0]  lanes;      // 1, 2 or 4
    logic        all_saved;  // all three sources captured, fields above stable

    modport capture
    (
        output htotal, hwidth, vtotal, vheight, fmt, stm_bw, lane_bw, lanes, all_saved
    );

    modport calc
    (
        input  htotal, hwidth, vtotal, vheight, fmt, stm_bw, lane_bw, lanes, all_saved
    );

endinterface

`default_nettype wire

// ==== td_pkg.sv ====
`default_nettype none

package td_pkg;

    // ==============================
    // transfer unit and fixed point
    // ==============================

    localparam int TU_SIZE      = 64;  // link symbols in one transfer unit
    localparam int FP_PRECISION = 10;  // fraction bits of the per-tu ratio, scale 1024
    localparam int SYMBOL_BITS  = 8;   // bits carried by one link symbol

    // ==============================
    // format codes
    // ==============================

    // the format word is {misc1[7:6], misc0[7:1]}
    // anything not listed here decodes as 10 bpc, 3 symbols per pixel
    localparam logic [8:0] FMT_RGB_8     = 9'h010;  // rgb, 8 bpc
    localparam logic [8:0] FMT_RGB_16    = 9'h040;  // rgb, 16 bpc
    localparam logic [8:0] FMT_YCC444_8  = 9'h016;  // ycbcr 4:4:4, 8 bpc
    localparam logic [8:0] FMT_YCC444_16 = 9'h046;  // ycbcr 4:4:4, 16 bpc

    // ==============================
    // widths
    // ==============================

    // the tu numerator is at most 16 + 6 + 10 bits, so anything from 32 up works
    localparam int DIV_WIDTH_DEFAULT = 48;

endpackage

`default_nettype wire
